// ==== coh_pkg.sv ====
package coh_pkg;

    // ------------------------------------------------------------
    // Cluster and address geometry
    // ------------------------------------------------------------

    // Four L1 caches share the L2
    localparam int NUM_CORES = 4;
    localparam int CORE_ID_W = 2;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Direct-mapped directory, one 32-bit word per line
    localparam int DIR_SETS = 16;
    localparam int IDX_W    = 4;
    localparam int TAG_W    = 26;

    // Index sits above the byte offset, tag above the index
    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = 6;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------

    typedef enum logic {
        COH_READ,
        COH_WRITE
    } coh_op_e;

    // MESI-style line state as kept in the directory
    typedef enum logic [1:0] {
        LS_I,
        LS_S,
        LS_E,
        LS_M
    } line_state_e;

    typedef enum logic {
        SNP_INV,
        SNP_DOWN
    } snoop_op_e;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------

    // Request from one L1, 65 bits
    typedef struct packed {
        coh_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } core_req_t;

    // Reply carries the data and the granted state, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        line_state_e         state;
    } core_rsp_t;

    // Snoop broadcast, 33 bits
    typedef struct packed {
        snoop_op_e           op;
        logic [ADDR_W-1:0]   addr;
    } snoop_t;

    // One directory line, 64 bits
    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        line_state_e          state;
        logic [NUM_CORES-1:0] sharers;
        logic [DATA_W-1:0]    data;
    } dir_entry_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [ADDR_W-1:0]   adr;
        logic [DATA_W-1:0]   dat;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic                ack;
        logic [DATA_W-1:0]   dat;
    } wb_s2m_t;

endpackage

// ==== core_req_arbiter.sv ====
module core_req_arbiter (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [coh_pkg::NUM_CORES-1:0]     req_valid_i,
    input  coh_pkg::core_req_t                req_i [coh_pkg::NUM_CORES],
    input  logic                              take_i,
    output logic                              grant_valid_o,
    output logic [coh_pkg::CORE_ID_W-1:0]     grant_id_o,
    output coh_pkg::core_req_t                grant_req_o,
    output logic [coh_pkg::NUM_CORES-1:0]     req_ready_o
);

    // Search starts here, one past the last winner
    logic [coh_pkg::CORE_ID_W-1:0] ptr_q;
    logic [coh_pkg::CORE_ID_W-1:0] cand;

    // ------------------------------------------------------------
    // Rotating priority search
    // ------------------------------------------------------------

    // Walk from the far end down so the core nearest the pointer wins
    // Index wraps through the natural width of cand
    always_comb begin
        grant_valid_o = 1'b0;
        grant_id_o    = '0;
        cand          = '0;
        for (int i = coh_pkg::NUM_CORES - 1; i >= 0; i--) begin
            cand = ptr_q + i[coh_pkg::CORE_ID_W-1:0];
            if (req_valid_i[cand]) begin
                grant_valid_o = 1'b1;
                grant_id_o    = cand;
            end
        end
    end

    assign grant_req_o = req_i[grant_id_o];

    // Ready pulses toward the winner only in the take cycle
    always_comb begin
        req_ready_o = '0;
        if (take_i && grant_valid_o) begin
            req_ready_o[grant_id_o] = 1'b1;
        end
    end

    // Pointer moves past the winner on take
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (take_i && grant_valid_o) begin
            ptr_q <= grant_id_o + 1'b1;
        end
    end

    // A core left waiting keeps its request up until it is accepted
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ($past(req_valid_i & ~req_ready_o) & ~req_valid_i) == '0);

endmodule

// ==== l2_directory.sv ====
module l2_directory (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic [coh_pkg::IDX_W-1:0]     lookup_idx_i,
    output coh_pkg::dir_entry_t           rd_entry_o,
    input  logic                          wr_en_i,
    input  logic [coh_pkg::IDX_W-1:0]     wr_idx_i,
    input  coh_pkg::dir_entry_t           wr_entry_i
);

    // ------------------------------------------------------------
    // Storage, one array per field
    // ------------------------------------------------------------

    // Only the state array is cleared by reset
    coh_pkg::line_state_e              state_q   [coh_pkg::DIR_SETS];

    // Tag, sharers and data are don't-care while the state is LS_I
    logic [coh_pkg::TAG_W-1:0]         tag_q     [coh_pkg::DIR_SETS];
    logic [coh_pkg::NUM_CORES-1:0]     sharers_q [coh_pkg::DIR_SETS];
    logic [coh_pkg::DATA_W-1:0]        data_q    [coh_pkg::DIR_SETS];

    // State array, every line invalid out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < coh_pkg::DIR_SETS; i++) begin
                state_q[i] <= coh_pkg::LS_I;
            end
        end else if (wr_en_i) begin
            state_q[wr_idx_i] <= wr_entry_i.state;
        end
    end

    // Payload fields
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_idx_i]     <= wr_entry_i.tag;
            sharers_q[wr_idx_i] <= wr_entry_i.sharers;
            data_q[wr_idx_i]    <= wr_entry_i.data;
        end
    end

    // ------------------------------------------------------------
    // Lookup port
    // ------------------------------------------------------------

    // Combinational read, a write shows up from the next cycle on
    always_comb begin
        rd_entry_o.tag     = tag_q[lookup_idx_i];
        rd_entry_o.state   = state_q[lookup_idx_i];
        rd_entry_o.sharers = sharers_q[lookup_idx_i];
        rd_entry_o.data    = data_q[lookup_idx_i];
    end

    // A modified line is owned by exactly one L1
    a_m_single_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_en_i && wr_entry_i.state == coh_pkg::LS_M) |-> $onehot(wr_entry_i.sharers));

endmodule

// ==== coherency_controller.sv ====
module coherency_controller (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Arbiter side
    input  logic                              grant_valid_i,
    input  logic [coh_pkg::CORE_ID_W-1:0]     grant_id_i,
    input  coh_pkg::core_req_t                grant_req_i,
    output logic                              take_o,
    // Directory side
    output logic [coh_pkg::IDX_W-1:0]         lookup_idx_o,
    input  coh_pkg::dir_entry_t               rd_entry_i,
    output logic                              wr_en_o,
    output logic [coh_pkg::IDX_W-1:0]         wr_idx_o,
    output coh_pkg::dir_entry_t               wr_entry_o,
    // Snoop and response side
    output logic [coh_pkg::NUM_CORES-1:0]     snoop_valid_o,
    output coh_pkg::snoop_t                   snoop_o,
    input  logic [coh_pkg::NUM_CORES-1:0]     snoop_ack_i,
    output logic [coh_pkg::NUM_CORES-1:0]     rsp_valid_o,
    output coh_pkg::core_rsp_t                rsp_o,
    input  logic [coh_pkg::NUM_CORES-1:0]     rsp_ready_i,
    // Wishbone master
    output coh_pkg::wb_m2s_t                  wb_o,
    input  coh_pkg::wb_s2m_t                  wb_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT_SNOOP,
        ST_WRITEBACK,
        ST_FETCH,
        ST_SNOOP,
        ST_UPDATE,
        ST_RESPOND
    } state_e;

    state_e                          state_q;
    coh_pkg::core_req_t              req_q;
    logic [coh_pkg::CORE_ID_W-1:0]   id_q;
    // Working copy of the line, victim first on a miss
    coh_pkg::dir_entry_t             line_q;
    coh_pkg::snoop_op_e              snp_op_q;
    // Snoop targets still owing an ack
    logic [coh_pkg::NUM_CORES-1:0]   pend_q;
    logic [coh_pkg::NUM_CORES-1:0]   pend_nxt;
    coh_pkg::wb_m2s_t                wb_q;

    logic [coh_pkg::TAG_W-1:0]       req_tag;
    logic [coh_pkg::IDX_W-1:0]       req_idx;
    logic [coh_pkg::ADDR_W-1:0]      line_addr;
    logic [coh_pkg::ADDR_W-1:0]      victim_addr;
    logic                            hit;

    // Request rule outputs
    coh_pkg::dir_entry_t             src_line;
    coh_pkg::dir_entry_t             upd_line;
    logic [coh_pkg::NUM_CORES-1:0]   req_bit;
    logic [coh_pkg::NUM_CORES-1:0]   others;
    logic [coh_pkg::NUM_CORES-1:0]   snp_tgt;
    coh_pkg::snoop_op_e              snp_op;

    // ------------------------------------------------------------
    // Address split and hit detect
    // ------------------------------------------------------------

    assign req_tag     = req_q.addr[coh_pkg::TAG_LSB +: coh_pkg::TAG_W];
    assign req_idx     = req_q.addr[coh_pkg::IDX_LSB +: coh_pkg::IDX_W];
    // Word-aligned addresses for memory and snoops
    assign line_addr   = {req_tag, req_idx, {coh_pkg::IDX_LSB{1'b0}}};
    assign victim_addr = {line_q.tag, req_idx, {coh_pkg::IDX_LSB{1'b0}}};

    assign hit = (rd_entry_i.state != coh_pkg::LS_I) && (rd_entry_i.tag == req_tag);

    // ------------------------------------------------------------
    // Request rules
    // ------------------------------------------------------------

    // Source is the directory line on lookup, the fetched word on fill
    always_comb begin
        src_line = rd_entry_i;
        if (state_q == ST_FETCH) begin
            src_line.tag     = req_tag;
            src_line.state   = coh_pkg::LS_I;
            src_line.sharers = '0;
            src_line.data    = wb_i.dat;
        end
        req_bit        = '0;
        req_bit[id_q]  = 1'b1;
        others         = src_line.sharers & ~req_bit;
        upd_line       = src_line;
        upd_line.tag   = req_tag;
        snp_tgt        = '0;
        snp_op         = coh_pkg::SNP_INV;
        if (req_q.op == coh_pkg::COH_WRITE) begin
            // Invalidate everyone else, requester becomes owner
            snp_tgt          = others;
            upd_line.state   = coh_pkg::LS_M;
            upd_line.sharers = req_bit;
            upd_line.data    = req_q.wdata;
        end else if (src_line.state == coh_pkg::LS_I) begin
            // Fresh fill with no holder
            upd_line.state   = coh_pkg::LS_E;
            upd_line.sharers = req_bit;
        end else if (others != '0) begin
            upd_line.state   = coh_pkg::LS_S;
            upd_line.sharers = src_line.sharers | req_bit;
            // E or M elsewhere needs a downgrade first
            if (src_line.state != coh_pkg::LS_S) begin
                snp_tgt = others;
                snp_op  = coh_pkg::SNP_DOWN;
            end
        end
        // Sole holder reading again keeps the line as it is
    end

    // ------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------

    assign pend_nxt = pend_q & ~snoop_ack_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            pend_q  <= '0;
            wb_q    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (grant_valid_i) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        pend_q  <= snp_tgt;
                        state_q <= (snp_tgt != '0) ? ST_SNOOP : ST_UPDATE;
                    end else if (rd_entry_i.state != coh_pkg::LS_I) begin
                        // Valid victim, clear it out of every L1 first
                        pend_q  <= rd_entry_i.sharers;
                        state_q <= ST_EVICT_SNOOP;
                    end else begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_EVICT_SNOOP: begin
                    pend_q <= pend_nxt;
                    if (pend_nxt == '0) begin
                        state_q <= (line_q.state == coh_pkg::LS_M) ? ST_WRITEBACK : ST_FETCH;
                    end
                end
                ST_WRITEBACK: begin
                    if (!wb_q.cyc) begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= 1'b1;
                        wb_q.adr <= victim_addr;
                        wb_q.dat <= line_q.data;
                    end else if (wb_i.ack) begin
                        // Bus idles one cycle before the fetch
                        wb_q.cyc <= 1'b0;
                        wb_q.stb <= 1'b0;
                        state_q  <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (!wb_q.cyc) begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= 1'b0;
                        wb_q.adr <= line_addr;
                    end else if (wb_i.ack) begin
                        wb_q.cyc <= 1'b0;
                        wb_q.stb <= 1'b0;
                        state_q  <= ST_UPDATE;
                    end
                end
                ST_SNOOP: begin
                    pend_q <= pend_nxt;
                    if (pend_nxt == '0) begin
                        state_q <= ST_UPDATE;
                    end
                end
                ST_UPDATE: begin
                    state_q <= ST_RESPOND;
                end
                ST_RESPOND: begin
                    if (rsp_ready_i[id_q]) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request and working line
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && grant_valid_i) begin
            req_q <= grant_req_i;
            id_q  <= grant_id_i;
        end
        if (state_q == ST_LOOKUP) begin
            line_q   <= hit ? upd_line : rd_entry_i;
            snp_op_q <= snp_op;
        end
        // Filled line already carries the request rule result
        if (state_q == ST_FETCH && wb_q.cyc && wb_i.ack) begin
            line_q <= upd_line;
        end
    end

    // ------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------

    assign take_o       = (state_q == ST_IDLE) && grant_valid_i;
    assign lookup_idx_o = req_idx;
    assign wr_en_o      = (state_q == ST_UPDATE);
    assign wr_idx_o     = req_idx;
    assign wr_entry_o   = line_q;
    assign wb_o         = wb_q;

    always_comb begin
        snoop_valid_o = '0;
        snoop_o.op    = coh_pkg::SNP_INV;
        snoop_o.addr  = victim_addr;
        if (state_q == ST_EVICT_SNOOP) begin
            snoop_valid_o = pend_q;
        end else if (state_q == ST_SNOOP) begin
            snoop_valid_o = pend_q;
            snoop_o.op    = snp_op_q;
            snoop_o.addr  = line_addr;
        end
    end

    // Granted state is the state the line was left in
    assign rsp_o.rdata = line_q.data;
    assign rsp_o.state = line_q.state;

    always_comb begin
        rsp_valid_o = '0;
        if (state_q == ST_RESPOND) begin
            rsp_valid_o[id_q] = 1'b1;
        end
    end

    // Bus request stays put with address and data until the slave acks
    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_o.cyc && !wb_i.ack) |=> (wb_o.cyc && wb_o.stb && $stable(wb_o.adr)
            && $stable(wb_o.we) && $stable(wb_o.dat)));

    // The requester never snoops itself on its own line
    a_no_self_snoop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == ST_SNOOP) |-> !snoop_valid_o[id_q]);

    // A stalled reply keeps its target and its payload
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((rsp_valid_o != '0) && ((rsp_valid_o & rsp_ready_i) == '0))
            |=> ($stable(rsp_valid_o) && $stable(rsp_o)));

endmodule

// ==== coherency_top.sv ====
module coherency_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Core request ports
    input  logic [coh_pkg::NUM_CORES-1:0]     req_valid_i,
    input  coh_pkg::core_req_t                req_i [coh_pkg::NUM_CORES],
    output logic [coh_pkg::NUM_CORES-1:0]     req_ready_o,
    // Core response ports
    output logic [coh_pkg::NUM_CORES-1:0]     rsp_valid_o,
    output coh_pkg::core_rsp_t                rsp_o,
    input  logic [coh_pkg::NUM_CORES-1:0]     rsp_ready_i,
    // Snoop broadcast
    output logic [coh_pkg::NUM_CORES-1:0]     snoop_valid_o,
    output coh_pkg::snoop_t                   snoop_o,
    input  logic [coh_pkg::NUM_CORES-1:0]     snoop_ack_i,
    // Memory
    output coh_pkg::wb_m2s_t                  wb_o,
    input  coh_pkg::wb_s2m_t                  wb_i
);

    logic                            grant_valid;
    logic [coh_pkg::CORE_ID_W-1:0]   grant_id;
    coh_pkg::core_req_t              grant_req;
    logic                            take;

    logic [coh_pkg::IDX_W-1:0]       lookup_idx;
    coh_pkg::dir_entry_t             rd_entry;
    logic                            wr_en;
    logic [coh_pkg::IDX_W-1:0]       wr_idx;
    coh_pkg::dir_entry_t             wr_entry;

    core_req_arbiter i_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .take_i        (take),
        .grant_valid_o (grant_valid),
        .grant_id_o    (grant_id),
        .grant_req_o   (grant_req),
        .req_ready_o   (req_ready_o)
    );

    l2_directory i_directory (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_idx_i (lookup_idx),
        .rd_entry_o   (rd_entry),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_entry_i   (wr_entry)
    );

    coherency_controller i_controller (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .grant_valid_i (grant_valid),
        .grant_id_i    (grant_id),
        .grant_req_i   (grant_req),
        .take_o        (take),
        .lookup_idx_o  (lookup_idx),
        .rd_entry_i    (rd_entry),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .wr_entry_o    (wr_entry),
        .snoop_valid_o (snoop_valid_o),
        .snoop_o       (snoop_o),
        .snoop_ack_i   (snoop_ack_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o),
        .rsp_ready_i   (rsp_ready_i),
        .wb_o          (wb_o),
        .wb_i          (wb_i)
    );

endmodule

// ==== tb_coherency_top.sv ====
module tb_coherency_top;

    // Worst directed test plus 200 random ops is near 5000 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NC = coh_pkg::NUM_CORES;

    // Expected outcome of one granted request
    typedef struct packed {
        logic [1:0]             core;
        logic [31:0]            rdata;
        coh_pkg::line_state_e   state;
        logic [NC-1:0]          ev_mask;
        logic [31:0]            ev_addr;
        logic [NC-1:0]          snp_mask;
        coh_pkg::snoop_op_e     snp_op;
        logic [31:0]            snp_addr;
        logic                   wb;
        logic [31:0]            wb_addr;
        logic [31:0]            wb_data;
        logic                   fetch;
        logic [31:0]            fetch_addr;
    } exp_t;

    logic clk_i, rst_ni;
    logic [NC-1:0] req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
    logic [NC-1:0] snoop_valid_o, snoop_ack_i;
    coh_pkg::core_req_t req_i [NC];
    coh_pkg::core_rsp_t rsp_o, last_rsp;
    coh_pkg::snoop_t    snoop_o;
    coh_pkg::wb_m2s_t   wb_o;
    coh_pkg::wb_s2m_t   wb_i;

    // Reference model state
    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [25:0] m_tag [16];
    coh_pkg::line_state_e m_st [16];
    logic [NC-1:0] m_sh [16];
    logic [31:0] m_dat [16];

    exp_t exp_q;
    logic [31:0] rng = 32'd81494;
    logic [NC-1:0] busy, taken;
    logic in_flight, stall_en;
    int rr_ptr, win, n_req, n_rsp, cycles, k, n;
    int snp_wait [NC];
    int wb_wait;

    coherency_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got=%h exp=%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // First valid core searching upward from the pointer
    function automatic int rr_pick(logic [NC-1:0] v, int p);
        int c;
        for (int i = 0; i < NC; i++) begin
            c = (p + i) % NC;
            if (v[c]) return c;
        end
        return -1;
    endfunction

    // ------------------------------------------------------------
    // Reference for the request rules, updates the model directory
    // ------------------------------------------------------------
    function automatic exp_t apply_ref(int core, coh_pkg::coh_op_e op,
                                       logic [31:0] addr, logic [31:0] wdata);
        exp_t e;
        logic [3:0] idx;
        logic [25:0] tag;
        logic [NC-1:0] bit_r, oth;
        idx = addr[5:2];
        tag = addr[31:6];
        bit_r = '0;
        bit_r[core] = 1'b1;
        e = '0;
        e.core = core[1:0];
        e.snp_addr = {addr[31:2], 2'b00};
        if (!(m_st[idx] != coh_pkg::LS_I && m_tag[idx] == tag)) begin
            if (m_st[idx] != coh_pkg::LS_I) begin
                // Victim leaves every L1, dirty data goes home
                e.ev_mask = m_sh[idx];
                e.ev_addr = {m_tag[idx], idx, 2'b00};
                if (m_st[idx] == coh_pkg::LS_M) begin
                    e.wb = 1'b1;
                    e.wb_addr = e.ev_addr;
                    e.wb_data = m_dat[idx];
                    ref_mem[e.ev_addr[9:2]] = m_dat[idx];
                end
            end
            e.fetch = 1'b1;
            e.fetch_addr = e.snp_addr;
            m_dat[idx] = ref_mem[addr[9:2]];
            m_st[idx] = coh_pkg::LS_I;
            m_sh[idx] = '0;
        end
        oth = m_sh[idx] & ~bit_r;
        if (op == coh_pkg::COH_WRITE) begin
            e.snp_mask = oth;
            e.snp_op = coh_pkg::SNP_INV;
            m_st[idx] = coh_pkg::LS_M;
            m_sh[idx] = bit_r;
            m_dat[idx] = wdata;
        end else if (m_st[idx] == coh_pkg::LS_I) begin
            m_st[idx] = coh_pkg::LS_E;
            m_sh[idx] = bit_r;
        end else if (oth != '0) begin
            if (m_st[idx] != coh_pkg::LS_S) begin
                e.snp_mask = oth;
                e.snp_op = coh_pkg::SNP_DOWN;
            end
            m_st[idx] = coh_pkg::LS_S;
            m_sh[idx] = m_sh[idx] | bit_r;
        end
        m_tag[idx] = tag;
        e.rdata = m_dat[idx];
        e.state = m_st[idx];
        return e;
    endfunction

    // ------------------------------------------------------------
    // Compare process, samples at the falling edge
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (req_ready_o != '0) begin
                check_val("req_ready_o onehot", 64'($onehot(req_ready_o)), 64'd1);
                check_val("in_flight", 64'(in_flight), 64'd0);
                win = rr_pick(req_valid_i, rr_ptr);
                check_val("req_ready_o", 64'(req_ready_o), 64'(1 << win));
                exp_q = apply_ref(win, req_i[win].op, req_i[win].addr, req_i[win].wdata);
                rr_ptr = (win + 1) % NC;
                taken[win] = 1'b1;
                in_flight = 1'b1;
            end
            if (snoop_valid_o != '0) begin
                if (exp_q.ev_mask != '0) begin
                    check_val("snoop_valid_o", 64'(snoop_valid_o), 64'(exp_q.ev_mask));
                    check_val("snoop_o.op", 64'(snoop_o.op), 64'(coh_pkg::SNP_INV));
                    check_val("snoop_o.addr", 64'(snoop_o.addr), 64'(exp_q.ev_addr));
                    exp_q.ev_mask = exp_q.ev_mask & ~snoop_ack_i;
                end else begin
                    check_val("snoop_valid_o", 64'(snoop_valid_o), 64'(exp_q.snp_mask));
                    check_val("snoop_o.op", 64'(snoop_o.op), 64'(exp_q.snp_op));
                    check_val("snoop_o.addr", 64'(snoop_o.addr), 64'(exp_q.snp_addr));
                    exp_q.snp_mask = exp_q.snp_mask & ~snoop_ack_i;
                end
            end
            // Classic cycle, strobe only ever inside cyc
            check_val("wb_o.stb", 64'(wb_o.stb), 64'(wb_o.cyc));
            if (wb_o.cyc) begin
                if (exp_q.wb) begin
                    check_val("wb_o.we", 64'(wb_o.we), 64'd1);
                    check_val("wb_o.adr", 64'(wb_o.adr), 64'(exp_q.wb_addr));
                    check_val("wb_o.dat", 64'(wb_o.dat), 64'(exp_q.wb_data));
                    if (wb_i.ack) exp_q.wb = 1'b0;
                end else begin
                    check_val("fetch expected", 64'(exp_q.fetch), 64'd1);
                    check_val("wb_o.we", 64'(wb_o.we), 64'd0);
                    check_val("wb_o.adr", 64'(wb_o.adr), 64'(exp_q.fetch_addr));
                    if (wb_i.ack) exp_q.fetch = 1'b0;
                end
            end
            // Reply must hold its value across every stalled cycle
            if (rsp_valid_o != '0) begin
                check_val("rsp_valid_o in flight", 64'(in_flight), 64'd1);
                check_val("rsp_valid_o", 64'(rsp_valid_o), 64'(1 << exp_q.core));
                check_val("rsp_o.rdata", 64'(rsp_o.rdata), 64'(exp_q.rdata));
                check_val("rsp_o.state", 64'(rsp_o.state), 64'(exp_q.state));
                check_val("pending snoops", 64'({exp_q.ev_mask, exp_q.snp_mask}), 64'd0);
                check_val("pending bus cycles", 64'({exp_q.wb, exp_q.fetch}), 64'd0);
                if (rsp_ready_i[exp_q.core]) begin
                    busy[exp_q.core] = 1'b0;
                    in_flight = 1'b0;
                    last_rsp = rsp_o;
                    n_rsp++;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Core, snoop and memory responders, driven after the edge
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        #1;
        for (int i = 0; i < NC; i++) begin
            if (taken[i]) begin
                req_valid_i[i] = 1'b0;
                taken[i] = 1'b0;
            end
            if (snoop_ack_i[i]) begin
                snoop_ack_i[i] = 1'b0;
            end else if (snoop_valid_o[i]) begin
                if (snp_wait[i] == 0) begin
                    snoop_ack_i[i] = 1'b1;
                    snp_wait[i] = next_rand() % 4;
                end else begin
                    snp_wait[i]--;
                end
            end
            rsp_ready_i[i] = stall_en ? (next_rand() % 3 != 0) : 1'b1;
        end
        if (wb_i.ack) begin
            wb_i.ack = 1'b0;
        end else if (wb_o.cyc && wb_o.stb) begin
            if (wb_wait == 0) begin
                wb_i.ack = 1'b1;
                if (wb_o.we) mem[wb_o.adr[9:2]] = wb_o.dat;
                else wb_i.dat = mem[wb_o.adr[9:2]];
                wb_wait = next_rand() % 4;
            end else begin
                wb_wait--;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within the cycle limit");
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    // Caller sits one unit after a rising edge
    task automatic post(int c, coh_pkg::coh_op_e op, logic [31:0] addr, logic [31:0] data);
        req_i[c] = '{op: op, addr: addr, wdata: data};
        req_valid_i[c] = 1'b1;
        busy[c] = 1'b1;
        n_req++;
    endtask

    task automatic run(int c, coh_pkg::coh_op_e op, logic [31:0] addr, logic [31:0] data);
        post(c, op, addr, data);
        while (busy[c]) step();
    endtask

    // Small address pool so hits, sharing and conflicts are common
    task automatic post_random(int c);
        logic [31:0] r;
        r = next_rand();
        post(c, coh_pkg::coh_op_e'(r[0]), {24'd0, r[5:4], r[9:8], 2'b00}, next_rand());
    endtask

    initial begin
        rst_ni = 1'b0;
        req_valid_i = '0;
        rsp_ready_i = '0;
        snoop_ack_i = '0;
        wb_i = '0;
        busy = '0;
        taken = '0;
        in_flight = 1'b0;
        stall_en = 1'b0;
        rr_ptr = 0;
        n_req = 0;
        n_rsp = 0;
        cycles = 0;
        wb_wait = 0;
        for (int i = 0; i < NC; i++) begin
            req_i[i] = '0;
            snp_wait[i] = 0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = next_rand();
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < 16; i++) begin
            m_st[i] = coh_pkg::LS_I;
        end
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        step();

        // Cold miss fills in E
        run(0, coh_pkg::COH_READ, 32'h40, 32'h0);
        check_val("rsp_o.state", 64'(last_rsp.state), 64'(coh_pkg::LS_E));
        check_val("rsp_o.rdata", 64'(last_rsp.rdata), 64'(mem[16]));
        // Sharing, then upgrade by write and downgrade of the writer
        run(1, coh_pkg::COH_READ, 32'h40, 32'h0);
        check_val("rsp_o.state", 64'(last_rsp.state), 64'(coh_pkg::LS_S));
        run(2, coh_pkg::COH_READ, 32'h40, 32'h0);
        run(1, coh_pkg::COH_WRITE, 32'h40, 32'hcafe0001);
        check_val("rsp_o.state", 64'(last_rsp.state), 64'(coh_pkg::LS_M));
        run(3, coh_pkg::COH_READ, 32'h40, 32'h0);
        check_val("rsp_o.rdata", 64'(last_rsp.rdata), 64'h0000_0000_cafe_0001);
        // Dirty victim at the same index
        run(2, coh_pkg::COH_WRITE, 32'h40, 32'h5eed0002);
        run(0, coh_pkg::COH_READ, 32'h80, 32'h0);
        check_val("mem[16]", 64'(mem[16]), 64'h0000_0000_5eed_0002);

        // All cores at once
        for (int i = 0; i < NC; i++) post_random(i);
        while (busy != '0) step();

        // Random run under back-pressure
        stall_en = 1'b1;
        k = 0;
        while (k < 200) begin
            n = next_rand() % NC;
            if (!busy[n]) begin
                post_random(n);
                k++;
            end
            step();
        end
        while (busy != '0) step();
        repeat (5) step();

        if (n_rsp == n_req) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Response count %0d differs from request count %0d", n_rsp, n_req);
            $display("TEST RESULT: FAIL");
            $fatal(1, "lost responses");
        end
    end

endmodule

// ==== compile.f ====
coh_pkg.sv
core_req_arbiter.sv
l2_directory.sv
coherency_controller.sv
coherency_top.sv
tb_coherency_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_coherency_top
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
